/* logic/conv_defs.svh */
`ifndef CONV_DEFS_SVH
`define CONV_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Layer geometry
////////////////////////////////////////////////////////////////////////////

// Pixel, weight and output word width
`define CONV_WIDTH 16
// Output channels computed side by side
`define CONV_LANES 4
// 3x3 kernel over 2 input channels
`define CONV_TAPS 18
// Output positions in one layer run
`define CONV_POSITIONS 4

// FIFO entries, also the credits held at reset
`define CONV_FIFO_DEPTH 4

// Accumulator bits kept after ReLU
`define CONV_Q_MSB 28
`define CONV_Q_LSB 14

`endif

/* logic/conv_pkg.sv */
package conv_pkg;

	`include "conv_defs.svh"

	// Tap index width, holds 0 .. CONV_TAPS-1
	localparam int TAP_W = 5;

	// One input activation
	typedef logic signed [`CONV_WIDTH-1:0] pixel_t;

	// Pixel plus its position inside the kernel window
	typedef struct packed {
		pixel_t pix;
		logic [TAP_W-1:0] tap;
	} tap_pix_t;

	// Double width so a full window of products fits
	typedef logic signed [2*`CONV_WIDTH-1:0] acc_t;

	// One quantized word per lane
	typedef logic [`CONV_LANES-1:0][`CONV_WIDTH-1:0] ofm_vec_t;

endpackage

/* logic/tap_credit_if.sv */
`timescale 1ns/1ps

// Streamer to FIFO link with credit return
// Source starts with CONV_FIFO_DEPTH credits, one spent per push
// so push needs no ready
interface tap_credit_if import conv_pkg::*; ();

	// Forward path
	logic push;
	tap_pix_t item;

	// One credit back per pulse
	logic credit;

	modport src (
		output push,
		output item,
		input credit
	);

	modport sink (
		input push,
		input item,
		output credit
	);

endinterface

/* logic/ifm_streamer.sv */
`timescale 1ns/1ps
`include "conv_defs.svh"

module ifm_streamer import conv_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input pixel_t in_pixel,
	output logic in_ready,
	tap_credit_if.src link
);

	localparam int CRED_W = $clog2(`CONV_FIFO_DEPTH + 1);
	localparam logic [TAP_W-1:0] LAST_TAP = TAP_W'(`CONV_TAPS - 1);

	logic [CRED_W-1:0] credits;
	logic [TAP_W-1:0] tap;
	logic accept;

	// Credit available means the FIFO has room reserved
	assign in_ready = (credits != '0);
	assign accept = in_valid && in_ready;

	////////////////////////////////////////////////////////////////////////////
	// Credit counter
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			credits <= CRED_W'(`CONV_FIFO_DEPTH);
		end else begin
			// Spend and return can overlap, then no change
			unique case ({accept, link.credit})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Tap tagging and forward register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tap <= '0;
			link.push <= 1'b0;
		end else begin
			link.push <= accept;
			if (accept) begin
				// Wrap at end of window
				tap <= (tap == LAST_TAP) ? '0 : tap + 1'b1;
			end
		end
	end

	// Payload only, no reset
	always_ff @(posedge clk) begin
		if (accept) begin
			link.item.pix <= in_pixel;
			link.item.tap <= tap;
		end
	end

	// Returned credits never exceed what the FIFO can hold
	a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
		credits <= CRED_W'(`CONV_FIFO_DEPTH));

endmodule

/* logic/tap_fifo.sv */
`timescale 1ns/1ps
`include "conv_defs.svh"

module tap_fifo import conv_pkg::*; (
	input logic clk,
	input logic rst_n,
	tap_credit_if.sink link,
	output logic out_valid,
	output tap_pix_t out_item
);

	localparam int PTR_W = $clog2(`CONV_FIFO_DEPTH);
	localparam int CNT_W = $clog2(`CONV_FIFO_DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(`CONV_FIFO_DEPTH - 1);

	tap_pix_t mem [`CONV_FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic pop;

	// Engine takes an item every cycle, so pop whenever non-empty
	assign pop = (count != '0);
	assign out_valid = pop;
	assign out_item = mem[rd_ptr];

	// Credit goes back in the pop cycle
	assign link.credit = pop;

	////////////////////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (link.push) begin
			mem[wr_ptr] <= link.item;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Pointers and occupancy
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (link.push) begin
				wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
			end
			// Simultaneous push and pop leaves count alone
			unique case ({link.push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Credit scheme in the streamer keeps pushes away from a full buffer
	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		link.push |-> (count != CNT_W'(`CONV_FIFO_DEPTH)));

endmodule

/* logic/expand_weight_rom.sv */
`timescale 1ns/1ps
`include "conv_defs.svh"

module expand_weight_rom import conv_pkg::*; (
	input logic [TAP_W-1:0] tap,
	output ofm_vec_t weights,
	output acc_t [`CONV_LANES-1:0] biases
);

	// Weights and biases carry 10 fractional bits
	localparam int FRAC = 1024;

	////////////////////////////////////////////////////////////////////////////
	// Synthetic weight table
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		int w;
		for (int l = 0; l < `CONV_LANES; l++) begin
			// Range -8 .. 7, spread over lanes and taps
			w = ((7 * l + 3 * int'(tap)) % 16) - 8;
			weights[l] = `CONV_WIDTH'(w * FRAC);
		end
	end

	// Lane biases, the first two negative
	always_comb begin
		for (int l = 0; l < `CONV_LANES; l++) begin
			biases[l] = acc_t'((256 * l - 384) * FRAC);
		end
	end

endmodule

/* logic/expand_conv_engine.sv */
`timescale 1ns/1ps
`include "conv_defs.svh"

module expand_conv_engine import conv_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input tap_pix_t in_item,
	input logic done_ack,
	output logic out_valid,
	output ofm_vec_t ofm,
	output logic layer_done
);

	localparam logic [TAP_W-1:0] LAST_TAP = TAP_W'(`CONV_TAPS - 1);
	localparam int Q_BITS = `CONV_Q_MSB - `CONV_Q_LSB + 1;
	localparam int POS_W = $clog2(`CONV_POSITIONS + 1);
	localparam logic [POS_W-1:0] LAST_POS = POS_W'(`CONV_POSITIONS - 1);

	ofm_vec_t weights;
	acc_t [`CONV_LANES-1:0] biases;
	acc_t [`CONV_LANES-1:0] acc;
	acc_t [`CONV_LANES-1:0] acc_nxt;
	acc_t [`CONV_LANES-1:0] res;
	ofm_vec_t ofm_nxt;
	logic first_tap;
	logic last_tap;
	logic res_valid;
	logic [POS_W-1:0] pos_cnt;
	logic [TAP_W-1:0] prev_tap;

	expand_weight_rom u_rom (
		.tap(in_item.tap),
		.weights(weights),
		.biases(biases)
	);

	assign first_tap = (in_item.tap == '0);
	assign last_tap = (in_item.tap == LAST_TAP);

	////////////////////////////////////////////////////////////////////////////
	// MAC lanes
	////////////////////////////////////////////////////////////////////////////

	// Tap 0 starts a fresh window
	always_comb begin
		for (int l = 0; l < `CONV_LANES; l++) begin
			acc_nxt[l] = (first_tap ? acc_t'(0) : acc[l])
				+ acc_t'($signed(in_item.pix)) * acc_t'($signed(weights[l]));
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			acc <= acc_nxt;
		end
	end

	// Snapshot on the last tap so the next window can start at once
	always_ff @(posedge clk) begin
		if (in_valid && last_tap) begin
			res <= acc_nxt;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= in_valid && last_tap;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Bias, ReLU, quantize
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		acc_t sum;
		for (int l = 0; l < `CONV_LANES; l++) begin
			sum = res[l] + biases[l];
			// Negative sums clamp to zero
			if (sum[2*`CONV_WIDTH-1]) begin
				ofm_nxt[l] = '0;
			end else begin
				ofm_nxt[l] = {{(`CONV_WIDTH - Q_BITS){1'b0}}, sum[`CONV_Q_MSB:`CONV_Q_LSB]};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (res_valid) begin
			ofm <= ofm_nxt;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= res_valid;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Layer end
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pos_cnt <= '0;
			layer_done <= 1'b0;
		end else begin
			if (out_valid) begin
				pos_cnt <= (pos_cnt == LAST_POS) ? '0 : pos_cnt + 1'b1;
			end
			// Sticky until acknowledged, a new end wins over ack
			if (out_valid && pos_cnt == LAST_POS) begin
				layer_done <= 1'b1;
			end else if (done_ack) begin
				layer_done <= 1'b0;
			end
		end
	end

	// Last tap seen, so the first pop after reset must be tap 0
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prev_tap <= LAST_TAP;
		end else if (in_valid) begin
			prev_tap <= in_item.tap;
		end
	end

	// Streamer tagging and FIFO order must keep taps in sequence
	a_tap_order: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |-> (in_item.tap == ((prev_tap == LAST_TAP) ? '0 : prev_tap + 1'b1)));

endmodule

/* logic/expand_layer_top.sv */
`timescale 1ns/1ps
`include "conv_defs.svh"

module expand_layer_top import conv_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input pixel_t in_pixel,
	output logic in_ready,
	input logic done_ack,
	output logic out_valid,
	output ofm_vec_t ofm,
	output logic layer_done
);

	// FIFO to engine, no back-pressure
	logic fifo_valid;
	tap_pix_t fifo_item;

	tap_credit_if u_link ();

	ifm_streamer u_streamer (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_pixel(in_pixel),
		.in_ready(in_ready),
		.link(u_link.src)
	);

	tap_fifo u_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.link(u_link.sink),
		.out_valid(fifo_valid),
		.out_item(fifo_item)
	);

	expand_conv_engine u_engine (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(fifo_valid),
		.in_item(fifo_item),
		.done_ack(done_ack),
		.out_valid(out_valid),
		.ofm(ofm),
		.layer_done(layer_done)
	);

endmodule

/* tb/tb_expand_layer.sv */
`timescale 1ns/1ps
`include "conv_defs.svh"

module tb_expand_layer import conv_pkg::*; ();

	// Windows sent: two single ones, then two full layers
	localparam int TOTAL_PIXELS = (2 + 2 * `CONV_POSITIONS) * `CONV_TAPS;
	localparam int WATCHDOG_CYCLES = TOTAL_PIXELS * 4 + 200;
	// One window in the MAC plus one tap of the next, FIFO side on top
	localparam int AHEAD_MAX = `CONV_TAPS + 1 + `CONV_FIFO_DEPTH;
	localparam int Q_BITS = `CONV_Q_MSB - `CONV_Q_LSB + 1;

	logic clk = 1'b0;
	logic rst_n;
	logic in_valid;
	pixel_t in_pixel;
	logic in_ready;
	logic done_ack;
	logic out_valid;
	ofm_vec_t ofm;
	logic layer_done;

	// Expected vectors, oldest first
	ofm_vec_t exp_q [$];
	string test_name;
	int accepted;
	int completed;

	expand_layer_top UUT (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_pixel(in_pixel),
		.in_ready(in_ready),
		.done_ack(done_ack),
		.out_valid(out_valid),
		.ofm(ofm),
		.layer_done(layer_done)
	);

	// 100 ns period
	always #50 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	// Weight ((7L + 3T) mod 16) - 8 and bias 256L - 384, both scaled by 2^10
	function automatic ofm_vec_t expected_ofm(input int win [`CONV_TAPS]);
		ofm_vec_t res;
		longint sum;
		int w;
		for (int l = 0; l < `CONV_LANES; l++) begin
			sum = longint'((256 * l - 384) * 1024);
			for (int t = 0; t < `CONV_TAPS; t++) begin
				w = ((7 * l + 3 * t) % 16) - 8;
				sum += longint'(win[t]) * longint'(w) * 1024;
			end
			// ReLU, then keep the quantized slice
			if (sum < 0) begin
				res[l] = '0;
			end else begin
				res[l] = `CONV_WIDTH'((sum >> `CONV_Q_LSB) & ((longint'(1) << Q_BITS) - 1));
			end
		end
		return res;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Failure reporting
	////////////////////////////////////////////////////////////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected) begin
			abort_run($sformatf("Fail %s expected %h actual %h", name, expected, actual));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers, all on the falling edge
	////////////////////////////////////////////////////////////////////////////

	task automatic apply_reset();
		rst_n = 1'b0;
		accepted = 0;
		completed = 0;
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	// Hold the pixel until in_ready lets it through
	task automatic send_pixel(input int p);
		in_valid = 1'b1;
		in_pixel = pixel_t'(p);
		while (!in_ready) @(negedge clk);
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	// Zero max_gap keeps in_valid high across the whole window
	task automatic send_window(input int win [`CONV_TAPS], input int max_gap);
		exp_q.push_back(expected_ofm(win));
		for (int t = 0; t < `CONV_TAPS; t++) begin
			send_pixel(win[t]);
			if (max_gap > 0) begin
				idle_cycles(int'($urandom_range(max_gap, 0)));
			end
		end
	endtask

	// Wait for all results, plus one cycle for layer_done
	task automatic drain_outputs();
		while (exp_q.size() != 0) @(negedge clk);
		@(negedge clk);
	endtask

	task automatic ack_layer();
		check_value("done_high", 64'd1, 64'(layer_done));
		idle_cycles(3);
		check_value("done_held", 64'd1, 64'(layer_done));
		done_ack = 1'b1;
		@(negedge clk);
		done_ack = 1'b0;
		check_value("done_cleared", 64'd0, 64'(layer_done));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Compare process
	////////////////////////////////////////////////////////////////////////////

	// Pixels taken by the DUT, counted on the edge that accepts them
	always @(posedge clk) begin
		if (rst_n && in_valid && in_ready) begin
			accepted++;
		end
	end

	always @(negedge clk) begin
		if (rst_n) begin
			// Input may only run ahead of finished windows by the pipeline
			check_value("credit_bound", 64'd1,
				64'((accepted - completed * `CONV_TAPS) <= AHEAD_MAX));
			if (out_valid) begin
				if (exp_q.size() == 0) begin
					abort_run("out_valid went high with no result expected");
				end else begin
					check_value(test_name, exp_q.pop_front(), ofm);
					completed++;
				end
			end
		end
	end

	// Watchdog, sized from the pixel count
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		abort_run("Timeout, the run did not finish in time");
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int win [`CONV_TAPS];
		void'($urandom(93));
		in_valid = 1'b0;
		in_pixel = '0;
		done_ack = 1'b0;
		test_name = "reset";
		apply_reset();
		@(negedge clk);
		if (in_ready !== 1'b1 || out_valid !== 1'b0 || layer_done !== 1'b0) begin
			abort_run("After reset in_ready is not high or out_valid or layer_done not low");
		end

		// Small positive ramp
		test_name = "small_positive";
		for (int t = 0; t < `CONV_TAPS; t++) begin
			win[t] = 8 * (t + 1);
		end
		send_window(win, 0);
		drain_outputs();

		// Large negative, magnitude follows the lane 0 weights
		test_name = "large_negative";
		for (int t = 0; t < `CONV_TAPS; t++) begin
			win[t] = -(128 * ((3 * t) % 16) + 1000);
		end
		send_window(win, 0);
		drain_outputs();
		// Only two positions so far
		check_value("done_early", 64'd0, 64'(layer_done));

		// Full layer, random pixels and gaps
		apply_reset();
		test_name = "random_layer";
		repeat (`CONV_POSITIONS) begin
			for (int t = 0; t < `CONV_TAPS; t++) begin
				win[t] = int'($urandom_range(4095, 0)) - 2048;
			end
			send_window(win, 2);
		end
		drain_outputs();
		ack_layer();

		// Back to back burst
		test_name = "burst_layer";
		repeat (`CONV_POSITIONS) begin
			for (int t = 0; t < `CONV_TAPS; t++) begin
				win[t] = int'($urandom_range(4095, 0)) - 2048;
			end
			send_window(win, 0);
		end
		drain_outputs();
		ack_layer();

		$display("Regression passed");
		$finish;
	end

endmodule

/* build.f */
+incdir+logic
logic/conv_pkg.sv
logic/tap_credit_if.sv
logic/ifm_streamer.sv
logic/tap_fifo.sv
logic/expand_weight_rom.sv
logic/expand_conv_engine.sv
logic/expand_layer_top.sv
tb/tb_expand_layer.sv

/* Makefile */
# Verilator build and run of the expand layer testbench

VERILATOR ?= verilator
TOP ?= tb_expand_layer
FLAGS ?= --binary --timing --assert -Wno-fatal
OBJ_DIR ?= obj_dir

.PHONY: sim clean

# Build the model, then run it; a $fatal gives a non-zero exit status
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f build.f
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
